// File: compile.f
verilog/obi_mem_pkg.sv
verilog/pma_check.sv
verilog/obi_port.sv
verilog/bus_ctrl.sv
verilog/wb_ram.sv
verilog/obi_mem_top.sv
bench/tb_obi_mem.sv

// File: bench/tb_obi_mem.sv
/*
 * Testbench for the OBI memory subsystem. Drives both OBI ports, one access
 * at a time from a table and then at random, and checks against a word model.
 * Random words come from a small pool in each region so reads hit written data.
 */

`timescale 1ns/1ps

module tb_obi_mem;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RST_CYCLES  = 5;
    localparam int RSP_LIMIT   = 16;
    localparam int N_DUAL      = 2;
    localparam int N_RANDOM    = 200;

    // One table row per access
    typedef struct packed {
        logic               instr;
        logic               we;
        obi_mem_pkg::addr_t addr;
        obi_mem_pkg::be_t   be;
        obi_mem_pkg::data_t wdata;
        obi_mem_pkg::data_t exp_rdata;
        logic               exp_err;
    } row_t;

    logic               clk_i;
    logic               rst_i;
    logic               instr_req_i;
    obi_mem_pkg::addr_t instr_addr_i;
    logic               instr_gnt_o;
    logic               instr_rvalid_o;
    logic               instr_err_o;
    obi_mem_pkg::data_t instr_rdata_o;
    logic               data_req_i;
    logic               data_we_i;
    obi_mem_pkg::addr_t data_addr_i;
    obi_mem_pkg::be_t   data_be_i;
    obi_mem_pkg::data_t data_wdata_i;
    logic               data_gnt_o;
    logic               data_rvalid_o;
    logic               data_err_o;
    obi_mem_pkg::data_t data_rdata_o;

    row_t               rows[$];
    // Expected RAM contents by word index for words written so far
    obi_mem_pkg::data_t model_mem [int];

    obi_mem_top DUT (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // Failure reporting and checks
    // ------------------------------------------------------------------------
    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic add_row(input logic instr, input logic we, input obi_mem_pkg::addr_t addr,
                           input obi_mem_pkg::be_t be, input obi_mem_pkg::data_t wdata,
                           input obi_mem_pkg::data_t exp_rdata, input logic exp_err);
        row_t r;
        r.instr     = instr;
        r.we        = we;
        r.addr      = addr;
        r.be        = be;
        r.wdata     = wdata;
        r.exp_rdata = exp_rdata;
        r.exp_err   = exp_err;
        rows.push_back(r);
    endtask

    // Byte-lane merge into the model by word index
    task automatic model_write(input obi_mem_pkg::addr_t addr, input obi_mem_pkg::be_t be,
                               input obi_mem_pkg::data_t wdata);
        int                 idx;
        obi_mem_pkg::data_t word;
        idx  = (addr >> 2) % obi_mem_pkg::RAM_WORDS;
        word = model_mem.exists(idx) ? model_mem[idx] : 'x;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        model_mem[idx] = word;
    endtask

    // ------------------------------------------------------------------------
    // Single access on one idle port
    // ------------------------------------------------------------------------
    task automatic apply_access(input logic instr, input logic we,
                                input obi_mem_pkg::addr_t addr, input obi_mem_pkg::be_t be,
                                input obi_mem_pkg::data_t wdata,
                                input obi_mem_pkg::data_t exp_rdata, input logic exp_err);
        int    waited;
        logic  rvalid;
        string pname;
        pname = instr ? "instr" : "data";
        @(posedge clk_i);
        #DRIVE_DELAY;
        if (instr) begin
            instr_req_i  = 1'b1;
            instr_addr_i = addr;
        end else begin
            data_req_i   = 1'b1;
            data_we_i    = we;
            data_addr_i  = addr;
            data_be_i    = be;
            data_wdata_i = wdata;
        end
        // Empty port grants in the request cycle
        @(negedge clk_i);
        if (!(instr ? instr_gnt_o : data_gnt_o)) begin
            $display("ERROR: %s port withheld grant while empty", pname);
            stop_with_failure();
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        instr_req_i = 1'b0;
        data_req_i  = 1'b0;
        waited      = 0;
        rvalid      = 1'b0;
        while (!rvalid && waited < RSP_LIMIT) begin
            @(negedge clk_i);
            waited++;
            rvalid = instr ? instr_rvalid_o : data_rvalid_o;
        end
        if (!rvalid) begin
            $display("ERROR: no rvalid on %s port within %0d cycles", pname, RSP_LIMIT);
            stop_with_failure();
        end
        compare_value({pname, "_err_o"}, instr ? instr_err_o : data_err_o, exp_err);
        // Write response data is not defined unless the write was denied
        if (!we || exp_err) begin
            compare_value({pname, "_rdata_o"}, instr ? instr_rdata_o : data_rdata_o,
                          exp_rdata);
        end
        // Negedges counted from the grant edge are 5 through Wishbone and 3 when denied
        compare_value({pname, " cycles to rvalid"}, waited, exp_err ? 3 : 5);
        @(negedge clk_i);
        compare_value({pname, "_rvalid_o"}, instr ? instr_rvalid_o : data_rvalid_o, 1'b0);
    endtask

    // Both ports request in the same cycle and d_first names the expected winner
    task automatic dual_read(input obi_mem_pkg::addr_t i_addr, input obi_mem_pkg::addr_t d_addr,
                             input obi_mem_pkg::data_t i_exp, input obi_mem_pkg::data_t d_exp,
                             input logic d_first);
        int   waited;
        logic i_seen;
        logic d_seen;
        @(posedge clk_i);
        #DRIVE_DELAY;
        instr_req_i  = 1'b1;
        instr_addr_i = i_addr;
        data_req_i   = 1'b1;
        data_we_i    = 1'b0;
        data_addr_i  = d_addr;
        data_be_i    = 4'hF;
        @(negedge clk_i);
        if (!(instr_gnt_o && data_gnt_o)) begin
            $display("ERROR: simultaneous requests were not both granted");
            stop_with_failure();
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        instr_req_i = 1'b0;
        data_req_i  = 1'b0;
        waited      = 0;
        i_seen      = 1'b0;
        d_seen      = 1'b0;
        while (!(i_seen && d_seen) && waited < 2 * RSP_LIMIT) begin
            @(negedge clk_i);
            waited++;
            // Round-robin winner answers first
            if ((instr_rvalid_o || data_rvalid_o) && !(i_seen || d_seen)) begin
                compare_value("data_rvalid_o first", data_rvalid_o, d_first);
            end
            if (instr_rvalid_o) begin
                compare_value("instr response count", i_seen, 1'b0);
                i_seen = 1'b1;
                compare_value("instr_err_o", instr_err_o, 1'b0);
                compare_value("instr_rdata_o", instr_rdata_o, i_exp);
            end
            if (data_rvalid_o) begin
                compare_value("data response count", d_seen, 1'b0);
                d_seen = 1'b1;
                compare_value("data_err_o", data_err_o, 1'b0);
                compare_value("data_rdata_o", data_rdata_o, d_exp);
            end
        end
        if (!(i_seen && d_seen)) begin
            $display("ERROR: simultaneous reads did not both complete");
            stop_with_failure();
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int                 kind;
        int                 idx;
        obi_mem_pkg::addr_t addr;
        obi_mem_pkg::be_t   be;
        obi_mem_pkg::data_t wdata;
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_addr_i  = '0;
        data_be_i    = '0;
        data_wdata_i = '0;
        void'($urandom(32'ha505));

        // First field is 1 for the instr port and 0 for the data port
        add_row(0, 1, 32'h0000_0010, 4'hF, 32'hDEAD_BEEF, 32'h0, 0);
        add_row(0, 0, 32'h0000_0010, 4'hF, 32'h0, 32'hDEAD_BEEF, 0);
        add_row(1, 0, 32'h0000_0010, 4'hF, 32'h0, 32'hDEAD_BEEF, 0);
        add_row(0, 1, 32'h0000_1020, 4'hF, 32'h1234_5678, 32'h0, 0);
        add_row(0, 0, 32'h0000_1020, 4'hF, 32'h0, 32'h1234_5678, 0);
        add_row(0, 1, 32'h0000_0010, 4'h5, 32'hA1B2_C3D4, 32'h0, 0);
        add_row(0, 0, 32'h0000_0010, 4'hF, 32'h0, 32'hDEB2_BED4, 0);
        add_row(0, 1, 32'h0000_1020, 4'h8, 32'h99AB_CDEF, 32'h0, 0);
        add_row(0, 0, 32'h0000_1020, 4'hF, 32'h0, 32'h9934_5678, 0);
        // Fetch from data-only region and accesses outside both regions
        add_row(1, 0, 32'h0000_1020, 4'hF, 32'h0, 32'h0, 1);
        add_row(1, 0, 32'h0000_2000, 4'hF, 32'h0, 32'h0, 1);
        add_row(0, 0, 32'h0000_2000, 4'hF, 32'h0, 32'h0, 1);
        add_row(0, 0, 32'hFFFF_FFFC, 4'hF, 32'h0, 32'h0, 1);
        // 0x2010 aliases word 4 so a leaked write would show at 0x10
        add_row(0, 1, 32'h0000_2010, 4'hF, 32'h0BAD_F00D, 32'h0, 1);
        add_row(0, 0, 32'h0000_0010, 4'hF, 32'h0, 32'hDEB2_BED4, 0);
        add_row(1, 0, 32'h0000_0013, 4'hF, 32'h0, 32'hDEB2_BED4, 0);

        repeat (RST_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_i = 1'b0;
        @(negedge clk_i);
        compare_value("instr_rvalid_o", instr_rvalid_o, 1'b0);
        compare_value("data_rvalid_o", data_rvalid_o, 1'b0);

        foreach (rows[n]) begin
            apply_access(rows[n].instr, rows[n].we, rows[n].addr, rows[n].be,
                         rows[n].wdata, rows[n].exp_rdata, rows[n].exp_err);
            if (rows[n].we && !rows[n].exp_err) begin
                model_write(rows[n].addr, rows[n].be, rows[n].wdata);
            end
        end

        // Instr went last in the table so data wins this round
        dual_read(32'h0000_0010, 32'h0000_1020, 32'hDEB2_BED4, 32'h9934_5678, 1'b1);
        // A lone data access hands the next round to instr
        apply_access(0, 0, 32'h0000_1020, 4'hF, '0, 32'h9934_5678, 0);
        dual_read(32'h0000_0013, 32'h0000_0010, 32'hDEB2_BED4, 32'hDEB2_BED4, 1'b0);

        // Random phase over 64 words at the bottom of each region
        for (int n = 0; n < N_RANDOM; n++) begin
            kind = $urandom % 3;
            idx  = ($urandom % 64) + (($urandom % 2) * 1024);
            addr = idx * 4;
            if (kind == 2 && idx >= 1024) begin
                apply_access(1, 0, addr, 4'hF, '0, '0, 1);
            end else if (kind != 0 && model_mem.exists(idx)) begin
                apply_access(kind == 2, 0, addr, 4'hF, '0, model_mem[idx], 0);
            end else begin
                // Unwritten words get a full word first
                be    = model_mem.exists(idx) ? obi_mem_pkg::be_t'($urandom % 16) : 4'hF;
                wdata = $urandom;
                apply_access(0, 1, addr, be, wdata, '0, 0);
                model_write(addr, be, wdata);
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

    // Watchdog allows 20 cycles per access, the lone access included
    initial begin
        time limit;
        #1;
        limit = (rows.size() + 2 * N_DUAL + 1 + N_RANDOM + RST_CYCLES) * 20 * CLK_PERIOD;
        #(limit);
        $display("ERROR: watchdog expired at %0t, run did not finish", $time);
        stop_with_failure();
    end

endmodule : tb_obi_mem

// File: verilog/obi_mem_top.sv
/*
 * Memory subsystem behind a core's OBI instruction and data ports.
 * One transaction outstanding per port, no rready back-pressure.
 * Misaligned accesses are not supported; address bits 1:0 are ignored.
 */

`timescale 1ns/1ps

module obi_mem_top (
    input  logic               clk_i,
    input  logic               rst_i,

    // OBI instruction port
    input  logic               instr_req_i,
    input  obi_mem_pkg::addr_t instr_addr_i,
    output logic               instr_gnt_o,
    output logic               instr_rvalid_o,
    output logic               instr_err_o,
    output obi_mem_pkg::data_t instr_rdata_o,

    // OBI data port
    input  logic               data_req_i,
    input  logic               data_we_i,
    input  obi_mem_pkg::addr_t data_addr_i,
    input  obi_mem_pkg::be_t   data_be_i,
    input  obi_mem_pkg::data_t data_wdata_i,
    output logic               data_gnt_o,
    output logic               data_rvalid_o,
    output logic               data_err_o,
    output obi_mem_pkg::data_t data_rdata_o
);

    // Port to controller
    logic                   i_pend;
    obi_mem_pkg::addr_t     i_addr;
    logic                   d_pend;
    logic                   d_we;
    obi_mem_pkg::addr_t     d_addr;
    obi_mem_pkg::be_t       d_be;
    obi_mem_pkg::data_t     d_wdata;
    logic                   i_done;
    logic                   d_done;
    logic                   rsp_err;
    obi_mem_pkg::data_t     rsp_rdata;

    // Checker
    obi_mem_pkg::addr_t     chk_addr;
    logic                   chk_fetch;
    logic                   chk_allow;

    // Wishbone
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    obi_mem_pkg::word_idx_t wb_adr;
    obi_mem_pkg::be_t       wb_sel;
    obi_mem_pkg::data_t     wb_wdat;
    obi_mem_pkg::data_t     wb_rdat;
    logic                   wb_ack;

    // ------------------------------------------------------------------------
    // OBI ports, write path only on the data side
    // ------------------------------------------------------------------------
    obi_port #(.HAS_WRITE(1'b0)) u_instr_port (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (instr_req_i),
        .we_i         (),
        .addr_i       (instr_addr_i),
        .be_i         (),
        .wdata_i      (),
        .gnt_o        (instr_gnt_o),
        .pend_o       (i_pend),
        .pend_addr_o  (i_addr),
        .pend_we_o    (),
        .pend_be_o    (),
        .pend_wdata_o (),
        .done_i       (i_done),
        .rsp_err_i    (rsp_err),
        .rsp_rdata_i  (rsp_rdata),
        .rvalid_o     (instr_rvalid_o),
        .err_o        (instr_err_o),
        .rdata_o      (instr_rdata_o)
    );

    obi_port #(.HAS_WRITE(1'b1)) u_data_port (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (data_req_i),
        .we_i         (data_we_i),
        .addr_i       (data_addr_i),
        .be_i         (data_be_i),
        .wdata_i      (data_wdata_i),
        .gnt_o        (data_gnt_o),
        .pend_o       (d_pend),
        .pend_addr_o  (d_addr),
        .pend_we_o    (d_we),
        .pend_be_o    (d_be),
        .pend_wdata_o (d_wdata),
        .done_i       (d_done),
        .rsp_err_i    (rsp_err),
        .rsp_rdata_i  (rsp_rdata),
        .rvalid_o     (data_rvalid_o),
        .err_o        (data_err_o),
        .rdata_o      (data_rdata_o)
    );

    // ------------------------------------------------------------------------
    // Controller, checker and RAM
    // ------------------------------------------------------------------------
    bus_ctrl u_bus_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .i_pend_i    (i_pend),
        .i_addr_i    (i_addr),
        .d_pend_i    (d_pend),
        .d_we_i      (d_we),
        .d_addr_i    (d_addr),
        .d_be_i      (d_be),
        .d_wdata_i   (d_wdata),
        .i_done_o    (i_done),
        .d_done_o    (d_done),
        .rsp_err_o   (rsp_err),
        .rsp_rdata_o (rsp_rdata),
        .chk_addr_o  (chk_addr),
        .chk_fetch_o (chk_fetch),
        .chk_allow_i (chk_allow),
        .wb_cyc_o    (wb_cyc),
        .wb_stb_o    (wb_stb),
        .wb_we_o     (wb_we),
        .wb_adr_o    (wb_adr),
        .wb_sel_o    (wb_sel),
        .wb_dat_o    (wb_wdat),
        .wb_dat_i    (wb_rdat),
        .wb_ack_i    (wb_ack)
    );

    pma_check u_pma_check (
        .addr_i  (chk_addr),
        .fetch_i (chk_fetch),
        .allow_o (chk_allow)
    );

    wb_ram u_wb_ram (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .cyc_i (wb_cyc),
        .stb_i (wb_stb),
        .we_i  (wb_we),
        .adr_i (wb_adr),
        .sel_i (wb_sel),
        .dat_i (wb_wdat),
        .dat_o (wb_rdat),
        .ack_o (wb_ack)
    );

endmodule : obi_mem_top

// File: verilog/wb_ram.sv
/*
 * Wishbone classic slave RAM, one word wide, byte-lane writes.
 * Ack is registered and lasts one cycle per strobe. Contents are not
 * cleared by reset.
 */

`timescale 1ns/1ps

module wb_ram (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   cyc_i,
    input  logic                   stb_i,
    input  logic                   we_i,
    input  obi_mem_pkg::word_idx_t adr_i,
    input  obi_mem_pkg::be_t       sel_i,
    input  obi_mem_pkg::data_t     dat_i,
    output obi_mem_pkg::data_t     dat_o,
    output logic                   ack_o
);

    obi_mem_pkg::data_t mem [obi_mem_pkg::RAM_WORDS];
    obi_mem_pkg::data_t dat_q;
    logic               ack_q;
    logic               access;

    // New access on a fresh strobe, not on the ack cycle
    assign access = cyc_i && stb_i && !ack_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Array and read data
    always_ff @(posedge clk_i) begin
        if (access) begin
            dat_q <= mem[adr_i];
            if (we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel_i[b]) begin
                        mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
                    end
                end
            end
        end
    end

    assign dat_o = dat_q;
    assign ack_o = ack_q;

    a_ack_stb : assert property (@(posedge clk_i) disable iff (rst_i)
        ack_o |-> stb_i);

endmodule : wb_ram

// File: verilog/bus_ctrl.sv
/*
 * Round-robin arbiter and Wishbone classic master for two OBI ports.
 * The data port wins first after reset. A denied access skips the bus
 * and returns an error with zero read data. Only the data port writes.
 */

`timescale 1ns/1ps

module bus_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_i,

    // Instruction port is read only
    input  logic                   i_pend_i,
    input  obi_mem_pkg::addr_t     i_addr_i,

    // Data port
    input  logic                   d_pend_i,
    input  logic                   d_we_i,
    input  obi_mem_pkg::addr_t     d_addr_i,
    input  obi_mem_pkg::be_t       d_be_i,
    input  obi_mem_pkg::data_t     d_wdata_i,

    // Completion towards the ports
    output logic                   i_done_o,
    output logic                   d_done_o,
    output logic                   rsp_err_o,
    output obi_mem_pkg::data_t     rsp_rdata_o,

    // Attribute checker
    output obi_mem_pkg::addr_t     chk_addr_o,
    output logic                   chk_fetch_o,
    input  logic                   chk_allow_i,

    // Wishbone classic master
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output obi_mem_pkg::word_idx_t wb_adr_o,
    output obi_mem_pkg::be_t       wb_sel_o,
    output obi_mem_pkg::data_t     wb_dat_o,
    input  obi_mem_pkg::data_t     wb_dat_i,
    input  logic                   wb_ack_i
);

    obi_mem_pkg::bus_state_e state_q;
    logic                    pick_data;
    logic                    sel_data_q;
    logic                    last_data_q;
    logic                    rsp_err_q;
    obi_mem_pkg::data_t      rsp_rdata_q;
    obi_mem_pkg::addr_t      sel_addr;

    // Data wins unless instr also waits and data went last
    assign pick_data = d_pend_i && (!i_pend_i || !last_data_q);

    // Checker only matters in ST_IDLE
    assign chk_addr_o  = pick_data ? d_addr_i : i_addr_i;
    assign chk_fetch_o = !pick_data;

    // ------------------------------------------------------------------------
    // Controller FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= obi_mem_pkg::ST_IDLE;
            sel_data_q  <= 1'b0;
            // Instr counts as served last so data goes first
            last_data_q <= 1'b0;
            rsp_err_q   <= 1'b0;
        end else begin
            case (state_q)
                obi_mem_pkg::ST_IDLE: begin
                    if (i_pend_i || d_pend_i) begin
                        sel_data_q  <= pick_data;
                        last_data_q <= pick_data;
                        if (chk_allow_i) begin
                            state_q <= obi_mem_pkg::ST_WB;
                        end else begin
                            // Denied access skips the bus cycle
                            rsp_err_q <= 1'b1;
                            state_q   <= obi_mem_pkg::ST_DONE;
                        end
                    end
                end
                obi_mem_pkg::ST_WB: begin
                    if (wb_ack_i) begin
                        rsp_err_q <= 1'b0;
                        state_q   <= obi_mem_pkg::ST_DONE;
                    end
                end
                default: begin
                    state_q <= obi_mem_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Response data is zero on error
    always_ff @(posedge clk_i) begin
        if (state_q == obi_mem_pkg::ST_IDLE) begin
            rsp_rdata_q <= '0;
        end else if (state_q == obi_mem_pkg::ST_WB && wb_ack_i) begin
            rsp_rdata_q <= wb_dat_i;
        end
    end

    // ------------------------------------------------------------------------
    // Wishbone drive held steady by the pending port registers
    // ------------------------------------------------------------------------
    assign sel_addr = sel_data_q ? d_addr_i : i_addr_i;

    assign wb_cyc_o = (state_q == obi_mem_pkg::ST_WB);
    assign wb_stb_o = (state_q == obi_mem_pkg::ST_WB);
    assign wb_we_o  = sel_data_q && d_we_i;
    assign wb_adr_o = sel_addr[$bits(obi_mem_pkg::word_idx_t)+1:2];
    assign wb_sel_o = sel_data_q ? d_be_i : 4'hF;
    assign wb_dat_o = d_wdata_i;

    // Completion pulse to the served port
    assign i_done_o    = (state_q == obi_mem_pkg::ST_DONE) && !sel_data_q;
    assign d_done_o    = (state_q == obi_mem_pkg::ST_DONE) && sel_data_q;
    assign rsp_err_o   = rsp_err_q;
    assign rsp_rdata_o = rsp_rdata_q;

    // Request stays up and unchanged until the slave acks
    a_wb_hold : assert property (@(posedge clk_i) disable iff (rst_i)
        (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o) &&
            $stable(wb_we_o) && $stable(wb_sel_o) && $stable(wb_dat_o)));

    // Completion only reaches a port that still waits
    a_i_done_pend : assert property (@(posedge clk_i) disable iff (rst_i)
        i_done_o |-> i_pend_i);

    a_d_done_pend : assert property (@(posedge clk_i) disable iff (rst_i)
        d_done_o |-> d_pend_i);

endmodule : bus_ctrl

// File: verilog/obi_port.sv
/*
 * One OBI port with a single outstanding transaction and no rready.
 * Grant is combinational on req while the port is empty. With HAS_WRITE
 * off the port only reads, and we_i, be_i and wdata_i are ignored.
 */

`timescale 1ns/1ps

module obi_port #(
    parameter bit HAS_WRITE = 1'b1
) (
    input  logic               clk_i,
    input  logic               rst_i,

    // OBI request phase
    input  logic               req_i,
    input  logic               we_i,
    input  obi_mem_pkg::addr_t addr_i,
    input  obi_mem_pkg::be_t   be_i,
    input  obi_mem_pkg::data_t wdata_i,
    output logic               gnt_o,

    // Captured request towards the controller
    output logic               pend_o,
    output obi_mem_pkg::addr_t pend_addr_o,
    output logic               pend_we_o,
    output obi_mem_pkg::be_t   pend_be_o,
    output obi_mem_pkg::data_t pend_wdata_o,

    // Completion from the controller
    input  logic               done_i,
    input  logic               rsp_err_i,
    input  obi_mem_pkg::data_t rsp_rdata_i,

    // OBI response phase
    output logic               rvalid_o,
    output logic               err_o,
    output obi_mem_pkg::data_t rdata_o
);

    logic               pend_q;
    logic               rvalid_q;
    logic               err_q;
    obi_mem_pkg::data_t rdata_q;
    obi_mem_pkg::addr_t addr_q;
    logic               we_q;
    obi_mem_pkg::be_t   be_q;
    obi_mem_pkg::data_t wdata_q;

    // Accept only when nothing is in flight
    assign gnt_o = req_i && !pend_q;

    // ------------------------------------------------------------------------
    // Pending flag and response valid
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pend_q   <= 1'b0;
            rvalid_q <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            // Single-cycle response pulse
            rvalid_q <= done_i;
            if (done_i) begin
                err_q  <= rsp_err_i;
                pend_q <= 1'b0;
            end else if (gnt_o) begin
                pend_q <= 1'b1;
            end
        end
    end

    // Captured request and response payload
    always_ff @(posedge clk_i) begin
        if (done_i) begin
            rdata_q <= rsp_rdata_i;
        end
        if (gnt_o) begin
            addr_q  <= addr_i;
            // Read-only port forces a full-word read
            we_q    <= HAS_WRITE ? we_i : 1'b0;
            be_q    <= HAS_WRITE ? be_i : 4'hF;
            wdata_q <= HAS_WRITE ? wdata_i : '0;
        end
    end

    assign pend_o       = pend_q;
    assign pend_addr_o  = addr_q;
    assign pend_we_o    = we_q;
    assign pend_be_o    = be_q;
    assign pend_wdata_o = wdata_q;

    assign rvalid_o = rvalid_q;
    assign err_o    = err_q;
    assign rdata_o  = rdata_q;

    // Requester holds the address stable until granted
    a_addr_stable : assert property (@(posedge clk_i) disable iff (rst_i)
        (req_i && !gnt_o) |=> $stable(addr_i));

endmodule : obi_port

// File: verilog/pma_check.sv
/*
 * Physical memory attribute check, purely combinational.
 * Fetches are allowed in the executable region only, data accesses in
 * either region. Anything outside both regions is denied.
 */

`timescale 1ns/1ps

module pma_check (
    input  obi_mem_pkg::addr_t addr_i,
    input  logic               fetch_i,
    output logic               allow_o
);

    logic in_exec;
    logic in_data;

    // Region hits, bounds are inclusive
    assign in_exec = (addr_i >= obi_mem_pkg::EXEC_BASE) &&
                     (addr_i <= obi_mem_pkg::EXEC_LAST);
    assign in_data = (addr_i >= obi_mem_pkg::DATA_BASE) &&
                     (addr_i <= obi_mem_pkg::DATA_LAST);

    // Data-only region is never executable
    assign allow_o = in_exec || (!fetch_i && in_data);

endmodule : pma_check

// File: verilog/obi_mem_pkg.sv
/*
 * Shared widths, memory map and controller states for the OBI memory.
 * Regions are fixed at build time. Addresses are byte addresses, and the
 * RAM is addressed by word, so the low two address bits are dropped.
 */

package obi_mem_pkg;

    // ------------------------------------------------------------------------
    // Basic widths
    // ------------------------------------------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  be_t;

    // 8 KiB of on-chip RAM
    localparam int RAM_WORDS = 2048;

    // Word index into the RAM array, 11 bits for 2048 words
    typedef logic [$clog2(RAM_WORDS)-1:0] word_idx_t;

    // ------------------------------------------------------------------------
    // Memory attribute regions
    // ------------------------------------------------------------------------
    // Executable main memory, fetch and data access
    localparam addr_t EXEC_BASE = 32'h0000_0000;
    localparam addr_t EXEC_LAST = 32'h0000_0FFF;

    // Data-only main memory, no fetch
    localparam addr_t DATA_BASE = 32'h0000_1000;
    localparam addr_t DATA_LAST = 32'h0000_1FFF;

    // Bus controller FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WB,
        ST_DONE
    } bus_state_e;

endpackage : obi_mem_pkg
